// File: design/packet_path_settings.svh
`ifndef PACKET_PATH_SETTINGS_SVH
`define PACKET_PATH_SETTINGS_SVH

// ==============================
// Beat format
// ==============================

// Data bytes carried by one beat
`define PACKET_DATA_BYTES 8

// Metadata word, repeated on every beat of a packet
`define PACKET_META_BITS 32

// ==============================
// Path sizing
// ==============================

// FIFO entries, equal to the sender's starting credit count
`define PACKET_FIFO_DEPTH 16

// Register stages between the input port and the FIFO
`define PACKET_PIPE_STAGES 4

`endif

// File: design/packet_path_pkg.sv
`default_nettype none

`include "packet_path_settings.svh"

package packet_path_pkg;

    // ==============================
    // Field types
    // ==============================

    // Beat payload, byte 0 in the most significant byte
    typedef logic [`PACKET_DATA_BYTES*8-1:0] packet_data_t;

    // Valid bytes in the last beat
    // 0 means the whole beat is valid
    typedef logic [$clog2(`PACKET_DATA_BYTES)-1:0] packet_mbytes_t;

    // Per-packet metadata
    typedef logic [`PACKET_META_BITS-1:0] packet_meta_t;

    // ==============================
    // Beat
    // ==============================

    // One transfer on either port
    // meta stays constant for all beats of a packet
    typedef struct packed {
        packet_data_t   data;
        logic           eop;
        packet_mbytes_t mbytes;
        packet_meta_t   meta;
    } packet_beat_t;

endpackage

`default_nettype wire

// File: design/packet_pipe.sv
`default_nettype none

module packet_pipe #(
    parameter int STAGES = 1
) (
    input  wire                           clk,
    input  wire                           arst_n,

    // Forward traffic
    input  wire                           in_valid,
    input  wire packet_path_pkg::packet_beat_t in_beat,
    output logic                          out_valid,
    output packet_path_pkg::packet_beat_t out_beat,

    // Credits travelling back towards the sender
    input  wire                           credit_back,
    output logic                          credit_up
);

    import packet_path_pkg::*;

    generate
        if (STAGES == 0) begin : g_wire

            // No routing delay in either direction
            assign out_valid = in_valid;
            assign out_beat  = in_beat;
            assign credit_up = credit_back;

        end else begin : g_stages

            // ==============================
            // Stage registers
            // ==============================

            logic [STAGES-1:0] valid_q;
            logic [STAGES-1:0] credit_q;
            packet_beat_t      beat_q [STAGES];

            // Valid and credit chains
            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    valid_q  <= '0;
                    credit_q <= '0;
                end
                else
                begin
                    valid_q[0]  <= in_valid;
                    credit_q[0] <= credit_back;
                    for (int i = 1; i < STAGES; i++)
                    begin
                        valid_q[i]  <= valid_q[i-1];
                        credit_q[i] <= credit_q[i-1];
                    end
                end
            end

            // Payload chain, loaded only where a beat is present
            always_ff @(posedge clk)
            begin
                if (in_valid)
                begin
                    beat_q[0] <= in_beat;
                end
                for (int i = 1; i < STAGES; i++)
                begin
                    if (valid_q[i-1])
                    begin
                        beat_q[i] <= beat_q[i-1];
                    end
                end
            end

            // ==============================
            // Outputs
            // ==============================

            // Last stage feeds the FIFO
            assign out_valid = valid_q[STAGES-1];
            assign out_beat  = beat_q[STAGES-1];

            // Credits leave after the same number of cycles
            assign credit_up = credit_q[STAGES-1];

        end
    endgenerate

endmodule

`default_nettype wire

// File: design/packet_fifo.sv
`default_nettype none

module packet_fifo #(
    parameter int DEPTH = 16
) (
    input  wire                           clk,
    input  wire                           arst_n,

    // Write side, flow controlled by credits returned on wr_credit
    input  wire                           wr_valid,
    input  wire packet_path_pkg::packet_beat_t wr_beat,
    output logic                          wr_credit,

    // Read side, flow controlled by credits received on rd_credit
    output logic                          rd_valid,
    output packet_path_pkg::packet_beat_t rd_beat,
    input  wire                           rd_credit,

    // Sticky, set by a write into a full buffer
    output logic                          overflow
);

    import packet_path_pkg::*;

    // ==============================
    // Sizing
    // ==============================

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);

    // Receiver may grant well ahead of the data
    localparam int CRED_W = 16;

    // ==============================
    // State
    // ==============================

    packet_beat_t      mem [DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;

    logic              full;
    logic              wr_en;
    logic              rd_en;

    // Circular increment for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
        begin
            return '0;
        end
        else
        begin
            return ptr + 1'b1;
        end
    endfunction

    // ==============================
    // Control
    // ==============================

    assign full  = (count == CNT_W'(DEPTH));

    // Writes into a full buffer are dropped
    assign wr_en = wr_valid && !full;

    // Read whenever data and an output credit are both present
    assign rd_en = (count != '0) && (credits != '0);

    // Pointers
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count <= '0;
        end
        else
        begin
            unique case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Output credits held, one spent per read
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            credits <= '0;
        end
        else
        begin
            unique case ({rd_credit, rd_en})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Overflow flag, cleared only by reset
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            overflow <= 1'b0;
        end
        else if (wr_valid && full)
        begin
            overflow <= 1'b1;
        end
    end

    // ==============================
    // Storage and read port
    // ==============================

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_beat <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_en;
        end
    end

    // Each departing beat frees one entry for the sender
    assign wr_credit = rd_valid;

endmodule

`default_nettype wire

// File: design/packet_path_top.sv
`default_nettype none

`include "packet_path_settings.svh"

module packet_path_top (
    input  wire                           clk,
    input  wire                           arst_n,

    // ==============================
    // Input port
    // ==============================

    // Sender starts with PACKET_FIFO_DEPTH credits
    input  wire                           in_valid,
    input  wire packet_path_pkg::packet_beat_t in_beat,
    output logic                          in_credit,

    // ==============================
    // Output port
    // ==============================

    // One beat per credit granted by the receiver
    output logic                          out_valid,
    output packet_path_pkg::packet_beat_t out_beat,
    input  wire                           out_credit,

    // Sender broke the credit rule
    output logic                          overflow
);

    import packet_path_pkg::*;

    // Between the pipe and the FIFO
    logic         pipe_valid;
    packet_beat_t pipe_beat;
    logic         fifo_credit;

    // ==============================
    // Routing stages
    // ==============================

    // Beats go forward, credits come back over the same distance
    packet_pipe #(
        .STAGES      (`PACKET_PIPE_STAGES)
    ) u_pipe (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_beat     (in_beat),
        .out_valid   (pipe_valid),
        .out_beat    (pipe_beat),
        .credit_back (fifo_credit),
        .credit_up   (in_credit)
    );

    // ==============================
    // Buffer and output port
    // ==============================

    // Depth matches the sender's credit pool
    packet_fifo #(
        .DEPTH       (`PACKET_FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_valid    (pipe_valid),
        .wr_beat     (pipe_beat),
        .wr_credit   (fifo_credit),
        .rd_valid    (out_valid),
        .rd_beat     (out_beat),
        .rd_credit   (out_credit),
        .overflow    (overflow)
    );

endmodule

`default_nettype wire

// File: test/packet_path_vectors.svh
`ifndef PACKET_PATH_VECTORS_SVH
`define PACKET_PATH_VECTORS_SVH

// Each row holds the length in bytes, the metadata word, the out_credit period
// and a flag that lets the sender ignore its credits
// Period 0 grants no output credits while that row runs

typedef struct packed {
    logic [15:0] len;
    logic [31:0] meta;
    logic [7:0]  period;
    logic        ignore_credits;
} vec_row_t;

vec_row_t vec_rows[$];

task automatic add_row(input int len, input logic [31:0] meta, input int period,
                       input bit ignore_credits);
    vec_row_t row;
    row.len            = 16'(len);
    row.meta           = meta;
    row.period         = 8'(period);
    row.ignore_credits = ignore_credits;
    vec_rows.push_back(row);
endtask

task automatic load_vectors();
    add_row(1,  32'h0000_0001, 1, 1'b0);
    add_row(8,  32'hA5A5_0002, 3, 1'b0);
    add_row(13, 32'h1234_5678, 2, 1'b0);
    // Output held off until the FIFO is full and the sender has no credits left
    add_row(64, 32'hDEAD_BEEF, 0, 1'b0);
    add_row(64, 32'h0BAD_F00D, 0, 1'b0);
    // Sender stalls here until drained beats return credits
    add_row(16, 32'hCAFE_0005, 5, 1'b0);
    add_row(33, 32'h8000_0000, 0, 1'b0);
    add_row(40, 32'h7FFF_FFFF, 2, 1'b0);
    add_row(24, 32'h0F0F_0F0F, 1, 1'b0);
    add_row(3,  32'hFFFF_FFFF, 4, 1'b0);
    add_row(57, 32'h3C3C_A5A5, 1, 1'b0);
    // Two beats more than the FIFO holds, sent without credits
    add_row((`PACKET_FIFO_DEPTH + 2) * `PACKET_DATA_BYTES, 32'h0F1F_0E1E, 0, 1'b1);
endtask

`endif

// File: test/packet_path_tb.sv
`default_nettype none

`include "packet_path_settings.svh"

module packet_path_tb;

    import packet_path_pkg::*;

    `include "packet_path_vectors.svh"

    logic         clk;
    logic         arst_n;
    logic         in_valid;
    packet_beat_t in_beat;
    logic         in_credit;
    logic         out_valid;
    packet_beat_t out_beat;
    logic         out_credit;
    logic         overflow;

    // Scoreboard and credit bookkeeping
    packet_beat_t exp_q[$];
    int errors;
    int tx_credits;
    int rx_held;
    int granted;
    int grant_target;
    int rx_period;
    int delivered;
    int returned;
    int exp_total;
    int cycles;
    int cycle_limit;
    bit ovf_allowed;
    bit ovf_seen;

    packet_path_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit),
        .overflow   (overflow)
    );

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Byte j of packet pkt is pkt*16+j, byte 0 in the top byte
    function automatic packet_beat_t make_beat(input int pkt, input int len, input int idx,
                                               input packet_meta_t meta);
        packet_beat_t beat;
        int nbeats;
        int j;
        nbeats = (len + `PACKET_DATA_BYTES - 1) / `PACKET_DATA_BYTES;
        beat   = '0;
        for (int i = 0; i < `PACKET_DATA_BYTES; i++)
        begin
            j = idx * `PACKET_DATA_BYTES + i;
            if (j < len)
                beat.data[(`PACKET_DATA_BYTES - 1 - i) * 8 +: 8] = 8'((pkt * 16 + j) % 256);
        end
        beat.eop    = (idx == nbeats - 1);
        beat.mbytes = beat.eop ? packet_mbytes_t'(len % `PACKET_DATA_BYTES) : '0;
        beat.meta   = meta;
        return beat;
    endfunction

    // Credit-aware sender, one beat per cycle while credits last
    task automatic send_packet(input int pkt, input vec_row_t row);
        packet_beat_t beat;
        int nbeats;
        int idx;
        nbeats = (row.len + `PACKET_DATA_BYTES - 1) / `PACKET_DATA_BYTES;
        idx    = 0;
        while (idx < nbeats)
        begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
            if (row.ignore_credits || tx_credits > 0)
            begin
                beat     = make_beat(pkt, row.len, idx, row.meta);
                in_beat  = beat;
                in_valid = 1'b1;
                tx_credits--;
                if (!row.ignore_credits)
                    exp_q.push_back(beat);
                idx++;
            end
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // ==============================
    // Clock, receiver, watchdog
    // ==============================

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Pacing receiver, stops granting once the current target is covered
    initial
    begin : receiver
        int wait_cnt;
        wait_cnt = 0;
        forever
        begin
            @(posedge clk);
            #2;
            out_credit = 1'b0;
            if (rx_period != 0 && granted < grant_target)
            begin
                wait_cnt++;
                if (wait_cnt >= rx_period)
                begin
                    out_credit = 1'b1;
                    granted++;
                    wait_cnt = 0;
                end
            end
        end
    end

    initial
    begin : watchdog
        cycles = 0;
        @(posedge clk);
        while (cycles < cycle_limit)
        begin
            cycles++;
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Checks done, %0d errors", errors);
        $display(">>> FAIL");
        $finish;
    end

    // ==============================
    // Output and credit monitor
    // ==============================

    always @(negedge clk)
    begin : monitor
        packet_beat_t exp;
        if (arst_n)
        begin
            if (out_valid)
            begin
                delivered++;
                if (rx_held == 0)
                    report_error("output beat sent without an output credit");
                else
                    rx_held--;
                if (exp_q.size() == 0)
                    report_error("output beat arrived with no packet outstanding");
                else
                begin
                    exp = exp_q.pop_front();
                    check_value("out_beat.data", out_beat.data, exp.data);
                    check_value("out_beat.eop", out_beat.eop, exp.eop);
                    check_value("out_beat.mbytes", out_beat.mbytes, exp.mbytes);
                    check_value("out_beat.meta", out_beat.meta, exp.meta);
                end
            end
            if (out_credit)
                rx_held++;
            if (in_credit)
            begin
                returned++;
                tx_credits++;
                if (tx_credits > `PACKET_FIFO_DEPTH)
                    report_error("sender credits went above the FIFO depth");
            end
            if (overflow && !ovf_allowed)
                report_error("overflow set while the sender kept the credit rule");
            if (overflow)
                ovf_seen = 1'b1;
            else if (ovf_seen)
                report_error("overflow flag cleared without a reset");
        end
    end

    // ==============================
    // Main sequence
    // ==============================

    initial
    begin : main
        vec_row_t row;
        int nbeats;
        void'($urandom(32'haf7b));
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        out_credit = 1'b0;
        errors = 0;
        tx_credits = `PACKET_FIFO_DEPTH;
        rx_held = 0;
        granted = 0;
        grant_target = 0;
        rx_period = 0;
        delivered = 0;
        returned = 0;
        exp_total = 0;
        ovf_allowed = 1'b0;
        ovf_seen = 1'b0;
        load_vectors();
        cycle_limit = 2000;
        foreach (vec_rows[k])
            cycle_limit += 4 * ((vec_rows[k].len + 7) / 8) * vec_rows[k].period;

        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("in_credit", in_credit, 1'b0);
        check_value("overflow", overflow, 1'b0);

        foreach (vec_rows[k])
        begin
            row    = vec_rows[k];
            nbeats = (row.len + `PACKET_DATA_BYTES - 1) / `PACKET_DATA_BYTES;
            @(posedge clk);
            if (row.ignore_credits)
                ovf_allowed = 1'b1;
            else
                exp_total += nbeats;
            rx_period    = row.period;
            grant_target = exp_total;
            send_packet(k, row);
            if (row.ignore_credits)
            begin
                repeat (`PACKET_PIPE_STAGES + 4) @(negedge clk);
                check_value("overflow", overflow, 1'b1);
                repeat (20) @(negedge clk);
            end
            else if (row.period != 0)
            begin
                while (delivered < exp_total)
                    @(posedge clk);
                // Credits come back a fixed pipe length after the last beat
                repeat (`PACKET_PIPE_STAGES + 2) @(posedge clk);
                check_value("in_credit total", returned, delivered);
                check_value("sender credits", tx_credits, `PACKET_FIFO_DEPTH);
            end
            repeat ($urandom_range(0, 3)) @(posedge clk);
        end

        check_value("beats outstanding", exp_q.size(), 0);
        $display("Checks done, %0d errors", errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: packet_path_top.f
+incdir+design
+incdir+test
design/packet_path_pkg.sv
design/packet_pipe.sv
design/packet_fifo.sv
design/packet_path_top.sv
test/packet_path_tb.sv

// File: Bender.yml
package:
  name: packet_path

sources:
  - include_dirs:
      - design
    files:
      - design/packet_path_pkg.sv
      - design/packet_pipe.sv
      - design/packet_fifo.sv
      - design/packet_path_top.sv

  - target: test
    include_dirs:
      - design
      - test
    files:
      - test/packet_path_tb.sv
